// ==== Makefile ====
TOP := rv_decode_stage_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/rv_decode_checker.sv ====
`timescale 1ns/1ps

module rv_decode_checker (
    input logic clk,
    input logic arst_n,
    input logic halt,
    input logic flush,
    input logic trap_clear,
    input logic out_valid,
    input logic instr_trap,
    input logic trap_pending
);

    reset_clears: assert property (@(posedge clk)
        !arst_n |-> (!out_valid && !instr_trap && !trap_pending))
        else $error("out_valid, instr_trap or trap_pending high during reset");

    // Flush turns the next result into a bubble
    flush_bubble: assert property (@(posedge clk) disable iff (!arst_n)
        (flush && !halt) |=> !out_valid)
        else $error("out_valid high in the cycle after a flush");

    trap_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
        instr_trap |-> out_valid)
        else $error("instr_trap high without out_valid");

    trap_captured: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && instr_trap && !trap_pending && !trap_clear) |=> trap_pending)
        else $error("trap_pending did not rise after a trapping result");

endmodule

// ==== bench/rv_decode_stage_tb.sv ====
`timescale 1ns/1ps

module rv_decode_stage_tb;

    import rv_pkg::*;

    typedef struct packed {
        riscv_instr_t instr;
        rv_pc_t       pc;
        rv32_opcode_e op;
        alu_op_e      alu;
        rv_register_t rd;
        rv_register_t rs1;
        rv_register_t rs2;
        rv_imm_t      imm;
        logic         trap;
    } row_t;

    localparam int WATCHDOG_CYCLES = 2000;

    logic         clk;
    logic         arst_n;
    logic         instr_valid;
    riscv_instr_t instr;
    rv_pc_t       pc;
    logic         halt;
    logic         flush;
    logic         wb_en;
    rv_register_t wb_rd;
    rv_data_t     wb_data;
    logic         trap_clear;
    logic         out_valid;
    logic         instr_trap;
    rv32_opcode_e rv_opcode;
    alu_op_e      alu_op;
    rv_register_t rv_rd;
    rv_register_t rv_rs1;
    rv_register_t rv_rs2;
    rv_imm_t      rv_imm;
    rv_data_t     rs1_data;
    rv_data_t     rs2_data;
    logic         trap_pending;
    rv_pc_t       cause_pc;
    riscv_instr_t cause_instr;

    row_t         rows[$];
    rv_data_t     model [32]; // Expected register file contents
    logic [15:0]  lfsr_state;
    int           errors;
    int           checks;
    int           tests;
    int           test_errors;

    rv_decode_stage #(
        .NUM_REGS (32)
    ) dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .halt         (halt),
        .flush        (flush),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .trap_clear   (trap_clear),
        .out_valid    (out_valid),
        .instr_trap   (instr_trap),
        .rv_opcode    (rv_opcode),
        .alu_op       (alu_op),
        .rv_rd        (rv_rd),
        .rv_rs1       (rv_rs1),
        .rv_rs2       (rv_rs2),
        .rv_imm       (rv_imm),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .trap_pending (trap_pending),
        .cause_pc     (cause_pc),
        .cause_instr  (cause_instr)
    );

    bind rv_decode_stage rv_decode_checker u_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .halt         (halt),
        .flush        (flush),
        .trap_clear   (trap_clear),
        .out_valid    (out_valid),
        .instr_trap   (instr_trap),
        .trap_pending (trap_pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Simulation timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    function automatic rv_data_t random_word();
        rv_data_t value;
        value = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic add_row(input riscv_instr_t word, input rv32_opcode_e op, input alu_op_e alu,
                           input rv_register_t rd, input rv_register_t rs1,
                           input rv_register_t rs2, input rv_imm_t imm, input logic trap);
        row_t r;
        r.instr = word;
        r.pc    = 32'h0000_1000 + 32'(4 * rows.size());
        r.op    = op;
        r.alu   = alu;
        r.rd    = rd;
        r.rs1   = rs1;
        r.rs2   = rs2;
        r.imm   = imm;
        r.trap  = trap;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(32'hABCDE0B7, RV32_LUI, ALU_PASS_B, 5'd1, 5'd0, 5'd0, 32'hABCDE000, 1'b0);
        add_row(32'hFFFFF117, RV32_AUIPC, ALU_ADD, 5'd2, 5'd0, 5'd0, 32'hFFFFF000, 1'b0);
        add_row(32'hFF9FF0EF, RV32_JAL, ALU_ADD, 5'd1, 5'd0, 5'd0, 32'hFFFFFFF8, 1'b0);
        add_row(32'hFFC281E7, RV32_JALR, ALU_ADD, 5'd3, 5'd5, 5'd0, 32'hFFFFFFFC, 1'b0);
        add_row(32'hFE7318E3, RV32_BNE, ALU_SUB, 5'd0, 5'd6, 5'd7, 32'hFFFFFFF0, 1'b0);
        add_row(32'hFEC4A403, RV32_LW, ALU_ADD, 5'd8, 5'd9, 5'd0, 32'hFFFFFFEC, 1'b0);
        add_row(32'hFCA5AE23, RV32_SW, ALU_ADD, 5'd0, 5'd11, 5'd10, 32'hFFFFFFDC, 1'b0);
        add_row(32'hFFF00293, RV32_ADDI, ALU_ADD, 5'd5, 5'd0, 5'd0, 32'hFFFFFFFF, 1'b0);
        add_row(32'h4076D613, RV32_SRAI, ALU_SRA, 5'd12, 5'd13, 5'd0, 32'h00000407, 1'b0);
        add_row(32'h41078733, RV32_SUB, ALU_SUB, 5'd14, 5'd15, 5'd16, 32'h0, 1'b0);
        add_row(32'hDEADBEFF, RV32_UNKNOWN, ALU_ADD, 5'd0, 5'd0, 5'd0, 32'h0, 1'b1);
        add_row(32'h0020A463, RV32_UNKNOWN, ALU_SUB, 5'd0, 5'd1, 5'd2, 32'h8, 1'b1);
        add_row(32'h802081B3, RV32_UNKNOWN, ALU_ADD, 5'd3, 5'd1, 5'd2, 32'h0, 1'b1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_row(input row_t r);
        check_value("out_valid", 32'(out_valid), 32'd1);
        check_value("instr_trap", 32'(instr_trap), 32'(r.trap));
        check_value("rv_opcode", 32'(rv_opcode), 32'(r.op));
        if (!r.trap) begin // Payload of illegal words is not defined
            check_value("alu_op", 32'(alu_op), 32'(r.alu));
            check_value("rv_rd", 32'(rv_rd), 32'(r.rd));
            check_value("rv_rs1", 32'(rv_rs1), 32'(r.rs1));
            check_value("rv_rs2", 32'(rv_rs2), 32'(r.rs2));
            check_value("rv_imm", rv_imm, r.imm);
        end
        check_value("rs1_data", rs1_data, model[r.instr[19:15]]);
        check_value("rs2_data", rs2_data, model[r.instr[24:20]]);
    endtask

    task automatic wait_trap_pending(input int max_cycles);
        int n = 0;
        while (trap_pending !== 1'b1 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        assert (trap_pending === 1'b1) else begin
            errors++;
            $display("trap_pending did not rise within %0d cycles", max_cycles);
        end
    endtask

    task automatic start_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("Test %s finished with %0d error(s)", name, errors - test_errors);
    endtask

    task automatic preload_registers();
        rv_data_t value;
        for (int r = 0; r < 32; r++) begin
            value = random_word();
            @(posedge clk);
            wb_en   <= 1'b1;
            wb_rd   <= 5'(r);
            wb_data <= value;
            if (r != 0) model[r] = value; // x0 ignores the write
        end
        @(posedge clk);
        wb_en <= 1'b0;
    endtask

    task automatic test_reset();
        start_test();
        @(negedge clk);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("instr_trap", 32'(instr_trap), 32'd0);
        check_value("trap_pending", 32'(trap_pending), 32'd0);
        check_value("cause_pc", cause_pc, 32'd0);
        check_value("cause_instr", cause_instr, 32'd0);
        check_value("rs1_data", rs1_data, 32'd0);
        end_test("reset");
    endtask

    task automatic test_decode_table();
        start_test();
        preload_registers();
        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge clk);
            if (i < rows.size()) begin
                instr       <= rows[i].instr;
                pc          <= rows[i].pc;
                instr_valid <= 1'b1;
            end else begin
                instr_valid <= 1'b0;
            end
            if (i > 0) begin // Result of the previous row
                @(negedge clk);
                check_row(rows[i-1]);
            end
        end
        end_test("decode table");
    endtask

    task automatic test_trap_status();
        int first;
        first = -1;
        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].trap && first < 0) first = i;
        end
        start_test();
        check_value("trap_pending", 32'(trap_pending), 32'd1);
        check_value("cause_pc", cause_pc, rows[first].pc);
        check_value("cause_instr", cause_instr, rows[first].instr);
        @(posedge clk);
        trap_clear <= 1'b1;
        @(posedge clk);
        trap_clear <= 1'b0;
        @(negedge clk);
        check_value("trap_pending", 32'(trap_pending), 32'd0);
        @(posedge clk);
        instr       <= rows[rows.size()-1].instr;
        pc          <= 32'h0000_2000;
        instr_valid <= 1'b1;
        @(posedge clk);
        instr_valid <= 1'b0;
        wait_trap_pending(8);
        check_value("cause_pc", cause_pc, 32'h0000_2000);
        check_value("cause_instr", cause_instr, rows[rows.size()-1].instr);
        end_test("trap status");
    endtask

    task automatic test_bypass();
        rv_data_t     new_value;
        rv_register_t bypass_reg;
        start_test();
        new_value  = random_word();
        bypass_reg = rows[9].instr[19:15];
        @(posedge clk);
        instr       <= rows[9].instr;
        pc          <= rows[9].pc;
        instr_valid <= 1'b1;
        wb_en       <= 1'b1;
        wb_rd       <= bypass_reg;
        wb_data     <= new_value;
        model[bypass_reg] = new_value; // Written and read on the same edge
        @(posedge clk);
        instr   <= rows[7].instr;
        pc      <= rows[7].pc;
        wb_rd   <= 5'd0;
        wb_data <= random_word();
        @(negedge clk);
        check_row(rows[9]);
        @(posedge clk);
        instr_valid <= 1'b0;
        wb_en       <= 1'b0;
        @(negedge clk);
        check_row(rows[7]); // x0 stays zero under a write
        end_test("write-back bypass");
    endtask

    task automatic test_halt_flush();
        rv_data_t     hold_data;
        rv_register_t hold_reg;
        start_test();
        hold_data = random_word();
        hold_reg  = rows[0].instr[19:15];
        @(posedge clk);
        instr       <= rows[0].instr;
        pc          <= rows[0].pc;
        instr_valid <= 1'b1;
        @(posedge clk);
        halt    <= 1'b1;
        instr   <= rows[8].instr;
        pc      <= rows[8].pc;
        wb_en   <= 1'b1;
        wb_rd   <= hold_reg;
        wb_data <= hold_data; // Must not reach rs1_data while halted
        @(negedge clk);
        check_row(rows[0]);
        @(posedge clk);
        wb_en <= 1'b0;
        for (int c = 0; c < 5; c++) begin
            @(negedge clk);
            check_row(rows[0]); // Stage holds the first row
        end
        if (hold_reg != '0) model[hold_reg] = hold_data;
        @(posedge clk);
        halt <= 1'b0;
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        check_row(rows[8]);
        @(posedge clk);
        instr       <= rows[10].instr;
        pc          <= rows[10].pc;
        instr_valid <= 1'b1;
        flush       <= 1'b1;
        @(posedge clk);
        instr_valid <= 1'b0;
        flush       <= 1'b0;
        @(negedge clk);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("instr_trap", 32'(instr_trap), 32'd0);
        end_test("halt and flush");
    endtask

    initial begin
        arst_n      <= 1'b0;
        instr_valid <= 1'b0;
        instr       <= '0;
        pc          <= '0;
        halt        <= 1'b0;
        flush       <= 1'b0;
        wb_en       <= 1'b0;
        wb_rd       <= '0;
        wb_data     <= '0;
        trap_clear  <= 1'b0;
        lfsr_state = 16'd62744;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        build_table();
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        test_reset();
        test_decode_table();
        test_trap_status();
        test_bypass();
        test_halt_flush();

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hdl/rv_pkg.sv
hdl/rv_imm_gen.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_trap_status.sv
hdl/rv_decode_stage.sv
bench/rv_decode_checker.sv
bench/rv_decode_stage_tb.sv

// ==== hdl/rv_decode_stage.sv ====
`timescale 1ns/1ps

module rv_decode_stage #(
    parameter int NUM_REGS = 32 // 32 for RV32I, 16 for RV32E
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 instr_valid,
    input  rv_pkg::riscv_instr_t instr,
    input  rv_pkg::rv_pc_t       pc,
    input  logic                 halt,
    input  logic                 flush,
    input  logic                 wb_en,
    input  rv_pkg::rv_register_t wb_rd,
    input  rv_pkg::rv_data_t     wb_data,
    input  logic                 trap_clear,
    output logic                 out_valid,
    output logic                 instr_trap,
    output rv_pkg::rv32_opcode_e rv_opcode,
    output rv_pkg::alu_op_e      alu_op,
    output rv_pkg::rv_register_t rv_rd,
    output rv_pkg::rv_register_t rv_rs1,
    output rv_pkg::rv_register_t rv_rs2,
    output rv_pkg::rv_imm_t      rv_imm,
    output rv_pkg::rv_data_t     rs1_data,
    output rv_pkg::rv_data_t     rs2_data,
    output logic                 trap_pending,
    output rv_pkg::rv_pc_t       cause_pc,
    output rv_pkg::riscv_instr_t cause_instr
);

    import rv_pkg::*;

    rv_register_t rd_addr1;
    rv_register_t rd_addr2;
    logic         rd_en;
    logic         trap_fire;
    rv_pc_t       trap_pc;
    riscv_instr_t trap_instr;

    rv_decoder #(
        .NUM_REGS (NUM_REGS)
    ) u_decoder (
        .clk         (clk),
        .arst_n      (arst_n),
        .halt        (halt),
        .flush       (flush),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rd_addr1    (rd_addr1),
        .rd_addr2    (rd_addr2),
        .rd_en       (rd_en),
        .out_valid   (out_valid),
        .instr_trap  (instr_trap),
        .trap_fire   (trap_fire),
        .rv_opcode   (rv_opcode),
        .alu_op      (alu_op),
        .rv_rd       (rv_rd),
        .rv_rs1      (rv_rs1),
        .rv_rs2      (rv_rs2),
        .rv_imm      (rv_imm),
        .trap_pc     (trap_pc),
        .trap_instr  (trap_instr)
    );

    rv_regfile #(
        .NUM_REGS (NUM_REGS)
    ) u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_en    (rd_en),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .rd_data1 (rs1_data),
        .rd_data2 (rs2_data),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    rv_trap_status u_trap_status (
        .clk          (clk),
        .arst_n       (arst_n),
        .trap_fire    (trap_fire),
        .trap_clear   (trap_clear),
        .trap_pc      (trap_pc),
        .trap_instr   (trap_instr),
        .trap_pending (trap_pending),
        .cause_pc     (cause_pc),
        .cause_instr  (cause_instr)
    );

endmodule

// ==== hdl/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder #(
    parameter int NUM_REGS = 32
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 halt,
    input  logic                 flush,
    input  logic                 instr_valid,
    input  rv_pkg::riscv_instr_t instr,
    input  rv_pkg::rv_pc_t       pc,
    output rv_pkg::rv_register_t rd_addr1,
    output rv_pkg::rv_register_t rd_addr2,
    output logic                 rd_en,
    output logic                 out_valid,
    output logic                 instr_trap,
    output logic                 trap_fire,
    output rv_pkg::rv32_opcode_e rv_opcode,
    output rv_pkg::alu_op_e      alu_op,
    output rv_pkg::rv_register_t rv_rd,
    output rv_pkg::rv_register_t rv_rs1,
    output rv_pkg::rv_register_t rv_rs2,
    output rv_pkg::rv_imm_t      rv_imm,
    output rv_pkg::rv_pc_t       trap_pc,
    output rv_pkg::riscv_instr_t trap_instr
);

    import rv_pkg::*;

    logic [OPCODE_W-1:0]  opcode;
    logic [FUNCT3_W-1:0]  funct3;
    logic [FUNCT7_W-1:0]  funct7;
    rv_register_t         field_rd;
    rv_register_t         field_rs1;
    rv_register_t         field_rs2;

    rv32_opcode_e         dec_opcode;
    alu_op_e              dec_alu;
    rv32_type_e           dec_type;
    rv_register_t         dec_rd;
    rv_register_t         dec_rs1;
    rv_register_t         dec_rs2;
    rv_imm_t              dec_imm;
    logic                 regs_in_range;
    logic                 dec_legal;
    logic                 load_en;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7    = instr[31:25];
    assign field_rd  = instr[11:7];
    assign field_rs1 = instr[19:15];
    assign field_rs2 = instr[24:20];

    always_comb begin
        dec_opcode = RV32_UNKNOWN;
        dec_alu    = ALU_ADD;
        dec_type   = RV32_TYPE_UNKNOWN;
        dec_rd     = '0;
        dec_rs1    = '0;
        dec_rs2    = '0;
        case (opcode)
            OPC_LUI: begin
                dec_type   = RV32_TYPE_U;
                dec_rd     = field_rd;
                dec_opcode = RV32_LUI;
                dec_alu    = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                dec_type   = RV32_TYPE_U;
                dec_rd     = field_rd;
                dec_opcode = RV32_AUIPC;
            end
            OPC_JAL: begin
                dec_type   = RV32_TYPE_J;
                dec_rd     = field_rd;
                dec_opcode = RV32_JAL;
            end
            OPC_JALR: begin
                dec_type = RV32_TYPE_I;
                dec_rd   = field_rd;
                dec_rs1  = field_rs1;
                if (funct3 == 3'b000) dec_opcode = RV32_JALR;
            end
            OPC_BRANCH: begin
                dec_type = RV32_TYPE_B;
                dec_rs1  = field_rs1;
                dec_rs2  = field_rs2;
                dec_alu  = ALU_SUB; // Compare by subtraction
                case (funct3)
                    3'b000:  dec_opcode = RV32_BEQ;
                    3'b001:  dec_opcode = RV32_BNE;
                    3'b100:  dec_opcode = RV32_BLT;
                    3'b101:  dec_opcode = RV32_BGE;
                    3'b110:  dec_opcode = RV32_BLTU;
                    3'b111:  dec_opcode = RV32_BGEU;
                    default: dec_opcode = RV32_UNKNOWN;
                endcase
            end
            OPC_LOAD: begin
                dec_type = RV32_TYPE_I;
                dec_rd   = field_rd;
                dec_rs1  = field_rs1;
                case (funct3)
                    3'b000:  dec_opcode = RV32_LB;
                    3'b001:  dec_opcode = RV32_LH;
                    3'b010:  dec_opcode = RV32_LW;
                    3'b100:  dec_opcode = RV32_LBU;
                    3'b101:  dec_opcode = RV32_LHU;
                    default: dec_opcode = RV32_UNKNOWN;
                endcase
            end
            OPC_STORE: begin
                dec_type = RV32_TYPE_S;
                dec_rs1  = field_rs1;
                dec_rs2  = field_rs2;
                case (funct3)
                    3'b000:  dec_opcode = RV32_SB;
                    3'b001:  dec_opcode = RV32_SH;
                    3'b010:  dec_opcode = RV32_SW;
                    default: dec_opcode = RV32_UNKNOWN;
                endcase
            end
            OPC_OP_IMM: begin
                dec_type = RV32_TYPE_I;
                dec_rd   = field_rd;
                dec_rs1  = field_rs1;
                case (funct3)
                    3'b000: dec_opcode = RV32_ADDI;
                    3'b010: {dec_opcode, dec_alu} = {RV32_SLTI, ALU_SLT};
                    3'b011: {dec_opcode, dec_alu} = {RV32_SLTIU, ALU_SLTU};
                    3'b100: {dec_opcode, dec_alu} = {RV32_XORI, ALU_XOR};
                    3'b110: {dec_opcode, dec_alu} = {RV32_ORI, ALU_OR};
                    3'b111: {dec_opcode, dec_alu} = {RV32_ANDI, ALU_AND};
                    3'b001: begin
                        if (funct7 == F7_BASE) {dec_opcode, dec_alu} = {RV32_SLLI, ALU_SLL};
                    end
                    default: begin // 3'b101, shift right
                        if (funct7 == F7_BASE) begin
                            {dec_opcode, dec_alu} = {RV32_SRLI, ALU_SRL};
                        end else if (funct7 == F7_ALT) begin
                            {dec_opcode, dec_alu} = {RV32_SRAI, ALU_SRA};
                        end
                    end
                endcase
            end
            OPC_OP: begin
                dec_type = RV32_TYPE_R;
                dec_rd   = field_rd;
                dec_rs1  = field_rs1;
                dec_rs2  = field_rs2;
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}: {dec_opcode, dec_alu} = {RV32_ADD, ALU_ADD};
                    {F7_ALT, 3'b000}:  {dec_opcode, dec_alu} = {RV32_SUB, ALU_SUB};
                    {F7_BASE, 3'b001}: {dec_opcode, dec_alu} = {RV32_SLL, ALU_SLL};
                    {F7_BASE, 3'b010}: {dec_opcode, dec_alu} = {RV32_SLT, ALU_SLT};
                    {F7_BASE, 3'b011}: {dec_opcode, dec_alu} = {RV32_SLTU, ALU_SLTU};
                    {F7_BASE, 3'b100}: {dec_opcode, dec_alu} = {RV32_XOR, ALU_XOR};
                    {F7_BASE, 3'b101}: {dec_opcode, dec_alu} = {RV32_SRL, ALU_SRL};
                    {F7_ALT, 3'b101}:  {dec_opcode, dec_alu} = {RV32_SRA, ALU_SRA};
                    {F7_BASE, 3'b110}: {dec_opcode, dec_alu} = {RV32_OR, ALU_OR};
                    {F7_BASE, 3'b111}: {dec_opcode, dec_alu} = {RV32_AND, ALU_AND};
                    default:           dec_opcode = RV32_UNKNOWN;
                endcase
            end
            OPC_MISC_MEM: begin
                dec_type = RV32_TYPE_I;
                if (funct3 == 3'b000) dec_opcode = RV32_FENCE; // No Zifencei
            end
            OPC_SYSTEM: begin
                dec_type = RV32_TYPE_I;
                if (funct3 == 3'b000) begin
                    if (instr[31:7] == 25'd0) dec_opcode = RV32_ECALL;
                    else if (instr[31:7] == {12'd1, 13'd0}) dec_opcode = RV32_EBREAK;
                end else if (funct3 != 3'b100) begin
                    dec_opcode = RV32_CSR;
                    dec_rd     = field_rd;
                    if (!funct3[2]) dec_rs1 = field_rs1; // Immediate forms use uimm
                end
            end
            default: begin
                dec_type = RV32_TYPE_UNKNOWN;
            end
        endcase
    end

    rv_imm_gen u_imm_gen (
        .instr    (instr),
        .imm_type (dec_type),
        .imm      (dec_imm)
    );

    // RV32E has no x16..x31
    assign regs_in_range = (int'(dec_rd) < NUM_REGS) && (int'(dec_rs1) < NUM_REGS)
                           && (int'(dec_rs2) < NUM_REGS);
    assign dec_legal = (dec_opcode != RV32_UNKNOWN) && regs_in_range;

    assign load_en   = instr_valid & ~halt;
    assign rd_en     = load_en; // Keeps operands aligned with payload
    assign rd_addr1  = field_rs1;
    assign rd_addr2  = field_rs2;
    assign trap_fire = out_valid & instr_trap;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            instr_trap <= 1'b0;
        end else if (!halt) begin
            out_valid  <= instr_valid & ~flush;
            instr_trap <= instr_valid & ~flush & ~dec_legal;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            rv_opcode  <= dec_opcode;
            alu_op     <= dec_alu;
            rv_rd      <= dec_rd;
            rv_rs1     <= dec_rs1;
            rv_rs2     <= dec_rs2;
            rv_imm     <= dec_imm;
            trap_pc    <= pc;
            trap_instr <= instr;
        end
    end

endmodule

// ==== hdl/rv_imm_gen.sv ====
`timescale 1ns/1ps

module rv_imm_gen (
    input  rv_pkg::riscv_instr_t instr,
    input  rv_pkg::rv32_type_e   imm_type,
    output rv_pkg::rv_imm_t      imm
);

    import rv_pkg::*;

    always_comb begin
        case (imm_type)
            RV32_TYPE_I: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            RV32_TYPE_S: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            RV32_TYPE_B: begin // Bit 0 always zero
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            RV32_TYPE_U: begin
                imm = {instr[31:12], 12'b0};
            end
            RV32_TYPE_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin // R and UNKNOWN carry no immediate
                imm = '0;
            end
        endcase
    end

endmodule

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int OPCODE_W  = 7;
    localparam int FUNCT3_W  = 3;
    localparam int FUNCT7_W  = 7;

    typedef logic [XLEN-1:0]      riscv_instr_t;
    typedef logic [XLEN-1:0]      rv_pc_t;
    typedef logic [XLEN-1:0]      rv_data_t;
    typedef logic [XLEN-1:0]      rv_imm_t;
    typedef logic [REG_IDX_W-1:0] rv_register_t;

    // Major opcodes, instr[6:0]
    localparam logic [OPCODE_W-1:0] OPC_LUI      = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [OPCODE_W-1:0] OPC_JAL      = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OPC_JALR     = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OPC_LOAD     = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OPC_STORE    = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OPC_OP       = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [OPCODE_W-1:0] OPC_SYSTEM   = 7'b1110011;

    localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000; // SUB, SRA, SRAI

    typedef enum logic [2:0] {
        RV32_TYPE_R,
        RV32_TYPE_I,
        RV32_TYPE_S,
        RV32_TYPE_B,
        RV32_TYPE_U,
        RV32_TYPE_J,
        RV32_TYPE_UNKNOWN
    } rv32_type_e;

    typedef enum logic [5:0] {
        RV32_LUI,
        RV32_AUIPC,
        RV32_JAL,
        RV32_JALR,
        RV32_BEQ,
        RV32_BNE,
        RV32_BLT,
        RV32_BGE,
        RV32_BLTU,
        RV32_BGEU,
        RV32_LB,
        RV32_LH,
        RV32_LW,
        RV32_LBU,
        RV32_LHU,
        RV32_SB,
        RV32_SH,
        RV32_SW,
        RV32_ADDI,
        RV32_SLTI,
        RV32_SLTIU,
        RV32_XORI,
        RV32_ORI,
        RV32_ANDI,
        RV32_SLLI,
        RV32_SRLI,
        RV32_SRAI,
        RV32_ADD,
        RV32_SUB,
        RV32_SLL,
        RV32_SLT,
        RV32_SLTU,
        RV32_XOR,
        RV32_SRL,
        RV32_SRA,
        RV32_OR,
        RV32_AND,
        RV32_ECALL,
        RV32_EBREAK,
        RV32_FENCE,
        RV32_CSR,     // All six Zicsr forms
        RV32_UNKNOWN
    } rv32_opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

endpackage

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile #(
    parameter int NUM_REGS = 32
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 rd_en,
    input  rv_pkg::rv_register_t rd_addr1,
    input  rv_pkg::rv_register_t rd_addr2,
    output rv_pkg::rv_data_t     rd_data1,
    output rv_pkg::rv_data_t     rd_data2,
    input  logic                 wb_en,
    input  rv_pkg::rv_register_t wb_rd,
    input  rv_pkg::rv_data_t     wb_data
);

    import rv_pkg::*;

    rv_data_t regs [1:NUM_REGS-1]; // x0 is not stored
    logic     wr_ok;

    assign wr_ok = wb_en && (wb_rd != '0) && (int'(wb_rd) < NUM_REGS);

    function automatic rv_data_t read_port(input rv_register_t addr);
        rv_data_t value;
        if (addr == '0 || int'(addr) >= NUM_REGS) begin
            value = '0;
        end else if (wr_ok && (wb_rd == addr)) begin
            value = wb_data; // Same-cycle bypass
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_data1 <= '0;
            rd_data2 <= '0;
        end else if (rd_en) begin
            rd_data1 <= read_port(rd_addr1);
            rd_data2 <= read_port(rd_addr2);
        end
    end

endmodule

// ==== hdl/rv_trap_status.sv ====
`timescale 1ns/1ps

module rv_trap_status (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 trap_fire,
    input  logic                 trap_clear,
    input  rv_pkg::rv_pc_t       trap_pc,
    input  rv_pkg::riscv_instr_t trap_instr,
    output logic                 trap_pending,
    output rv_pkg::rv_pc_t       cause_pc,
    output rv_pkg::riscv_instr_t cause_instr
);

    import rv_pkg::*;

    logic capture;

    // Only the first trap after a clear is recorded
    assign capture = trap_fire & ~trap_pending & ~trap_clear;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            trap_pending <= 1'b0;
            cause_pc     <= '0;
            cause_instr  <= '0;
        end else if (trap_clear) begin
            trap_pending <= 1'b0;
        end else if (capture) begin
            trap_pending <= 1'b1;
            cause_pc     <= rv_pc_t'(trap_pc);
            cause_instr  <= trap_instr;
        end
    end

endmodule
